// ==== clock_ctrl_pkg.sv ====
package clock_ctrl_pkg;

	//------------------------------------------------------------------------
	// Comparator clock phase stepping
	//------------------------------------------------------------------------
	localparam int CMP_STEPS     = 32;   // Coarse phase codes
	localparam int CMP_SEL_W     = 5;
	localparam int CMP_PHASE_W   = 11;
	// 56 steps per VCO period, 24 VCO periods per 25 ns
	localparam int CMP_FULL_TURN = 1344;

	//------------------------------------------------------------------------
	// Sampling clock manager reset and deserializer holdoff
	//------------------------------------------------------------------------
	localparam int RST_PIPE_LEN  = 8;
	localparam int TICKS_PER_US  = 40;   // CLK40 cycles
	localparam int PRESC_W       = $clog2(TICKS_PER_US);
	localparam int HOLDOFF_US    = 100;
	localparam int HOLDOFF_W     = 8;

	// Sampling clock phase selects, bit 0 is the fine select
	typedef struct packed {
		logic half_sel;   // Selects 20 MHz input polarity
		logic mid_sel;
		logic fine_sel;
	} samp_phase_t;

	typedef logic [CMP_PHASE_W-1:0] cmp_phase_t;

	typedef enum logic [2:0] {
		PS_IDLE    = 3'd0,
		PS_STEP    = 3'd1,
		PS_WAIT    = 3'd2,
		PS_SETTLE1 = 3'd3,
		PS_SETTLE2 = 3'd4
	} phs_state_t;

	// Sampling side status
	typedef struct packed {
		logic lead_edg_resync;
		logic cap_phase;
		logic c20_phase_sel;
		logic samp_in_sel;
		logic rst_samp_mmcm;
		logic dsr_resync;
	} samp_status_t;

	// Comparator side status
	typedef struct packed {
		cmp_phase_t cmp_phase;
		logic       phs_change;
		logic       psen;
		logic       psincdec;
		logic       busy;
		phs_state_t state;
	} cmp_status_t;

endpackage

// ==== resync_align.sv ====
module resync_align (
	input  logic CLK40,
	input  logic RST,
	input  logic resync_i,
	output logic lead_edg_resync_o,
	output logic cap_phase_o,
	output logic c20_phase_sel_o
);

	logic resync_d1;
	logic lead_edg_d1;
	logic cap_phase;
	logic cap_phase_d1;
	logic cap_ena;
	logic clk20_phase;
	logic c20_phase_sel;

	assign lead_edg_resync_o = resync_i & ~resync_d1;   // One clock wide

	//------------------------------------------------------------------------
	// Edge history and capture window
	//------------------------------------------------------------------------
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			resync_d1    <= 1'b0;
			lead_edg_d1  <= 1'b0;
			cap_phase    <= 1'b0;
			cap_phase_d1 <= 1'b0;
		end else begin
			resync_d1    <= resync_i;
			lead_edg_d1  <= lead_edg_resync_o;
			// Two cycles wide while enabled
			cap_phase    <= (lead_edg_resync_o | lead_edg_d1) & cap_ena;
			cap_phase_d1 <= cap_phase;
		end
	end

	// Only the first resync after reset gets to capture
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			cap_ena <= 1'b1;
		else if (cap_phase_d1)
			cap_ena <= 1'b0;
	end

	// Free running divide by two, realigned on every resync
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			clk20_phase <= 1'b0;
		else if (lead_edg_resync_o)
			clk20_phase <= 1'b0;
		else
			clk20_phase <= ~clk20_phase;
	end

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			c20_phase_sel <= 1'b0;
		else if (cap_phase)
			c20_phase_sel <= clk20_phase;   // Second load wins
	end

	assign cap_phase_o     = cap_phase;
	assign c20_phase_sel_o = c20_phase_sel;

endmodule

// ==== samp_clk_ctrl.sv ====
module samp_clk_ctrl (
	input  logic CLK40,
	input  logic RST,
	input  logic half_sel_i,
	input  logic c20_phase_sel_i,
	input  logic samp_clk_phs_chng_i,
	output logic samp_in_sel_o,
	output logic rst_samp_mmcm_o,
	output logic holdoff_req_o
);

	logic                                    samp_in_sel_d1;
	logic                                    rst_d1;
	logic                                    rst_d2;
	logic                                    samp_in_sel_chng;
	logic                                    trl_edg_rst;
	logic                                    pipe_in;
	logic [clock_ctrl_pkg::RST_PIPE_LEN-1:0] rst_pipe;

	// Input polarity of the sampling clock manager
	assign samp_in_sel_o = half_sel_i ^ c20_phase_sel_i;

	// Plain delay stages, these track RST itself
	always_ff @(posedge CLK40) begin
		rst_d1         <= RST;
		rst_d2         <= rst_d1;
		samp_in_sel_d1 <= samp_in_sel_o;
	end

	assign samp_in_sel_chng = samp_in_sel_o ^ samp_in_sel_d1;   // One clock wide
	assign trl_edg_rst      = ~RST & rst_d2;                     // Two clocks wide
	assign pipe_in          = samp_in_sel_chng | trl_edg_rst;

	//------------------------------------------------------------------------
	// Reset stretcher for the sampling clock manager
	//------------------------------------------------------------------------
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			rst_pipe <= '0;
		else
			rst_pipe <= {rst_pipe[clock_ctrl_pkg::RST_PIPE_LEN-2:0], pipe_in};
	end

	// High while any stage still holds a request
	assign rst_samp_mmcm_o = |rst_pipe;

	// Deserializer has to be resynced after any sampling clock disturbance
	assign holdoff_req_o = pipe_in | samp_clk_phs_chng_i;

endmodule

// ==== dsr_holdoff.sv ====
module dsr_holdoff (
	input  logic CLK40,
	input  logic RST,
	input  logic holdoff_req_i,
	output logic dsr_resync_o
);

	logic                                 dsr_ho;
	logic [clock_ctrl_pkg::PRESC_W-1:0]   presc;
	logic [clock_ctrl_pkg::HOLDOFF_W-1:0] us_cnt;
	logic                                 us_tick;
	logic                                 ho_done;

	assign us_tick = (presc == clock_ctrl_pkg::PRESC_W'(clock_ctrl_pkg::TICKS_PER_US - 1));
	// Counter reaching 100 us ends the holdoff
	assign ho_done = dsr_ho & us_tick
		& (us_cnt == clock_ctrl_pkg::HOLDOFF_W'(clock_ctrl_pkg::HOLDOFF_US - 1));

	// Microsecond prescaler and timer, idle at zero
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			presc  <= '0;
			us_cnt <= '0;
		end else if (!dsr_ho || ho_done) begin
			presc  <= '0;
			us_cnt <= '0;
		end else if (us_tick) begin
			presc  <= '0;
			us_cnt <= us_cnt + 1'b1;
		end else begin
			presc  <= presc + 1'b1;
		end
	end

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			dsr_ho <= 1'b0;
		else if (holdoff_req_i)
			dsr_ho <= 1'b1;   // Request beats the clear
		else if (ho_done)
			dsr_ho <= 1'b0;
	end

	assign dsr_resync_o = dsr_ho;

endmodule

// ==== cmp_phase_tracker.sv ====
module cmp_phase_tracker (
	input  logic                                 CLK40,
	input  logic                                 cmp_phs_rst_i,
	input  logic [clock_ctrl_pkg::CMP_SEL_W-1:0] cmp_clk_phase_i,
	input  logic                                 psen_i,
	output clock_ctrl_pkg::cmp_phase_t           cmp_phase_o,
	output logic                                 psincdec_o,
	output logic                                 phs_change_o
);

	//------------------------------------------------------------------------
	// Phase table
	// 32 codes per 25 ns spread over 1344 fine steps
	//------------------------------------------------------------------------
	clock_ctrl_pkg::cmp_phase_t cmp_rom [0:clock_ctrl_pkg::CMP_STEPS-1];

	initial begin
		$readmemh("cmp_phase.mem", cmp_rom);
	end

	clock_ctrl_pkg::cmp_phase_t target;
	clock_ctrl_pkg::cmp_phase_t cur_phase;   // Phase presumed inside the manager
	logic                       phs_inc;
	logic                       phs_chg_m1;
	logic                       phs_change;

	// Fine phase target of the selected code
	always_ff @(posedge CLK40) begin
		target <= cmp_rom[cmp_clk_phase_i];
	end

	always_ff @(posedge CLK40 or posedge cmp_phs_rst_i) begin
		if (cmp_phs_rst_i) begin
			phs_inc    <= 1'b0;
			phs_chg_m1 <= 1'b0;
			phs_change <= 1'b0;
		end else begin
			phs_inc    <= (target > cur_phase);
			phs_chg_m1 <= (target != cur_phase);
			phs_change <= phs_chg_m1;   // Extra stage lets a step settle
		end
	end

	// One fine step per psen from the manager preset of 0
	always_ff @(posedge CLK40 or posedge cmp_phs_rst_i) begin
		if (cmp_phs_rst_i)
			cur_phase <= '0;
		else if (psen_i) begin
			if (phs_inc)
				cur_phase <= cur_phase + 1'b1;
			else
				cur_phase <= cur_phase - 1'b1;
		end
	end

	assign cmp_phase_o  = target;
	assign psincdec_o   = phs_inc;
	assign phs_change_o = phs_change;

endmodule

// ==== dyn_phase_shift_fsm.sv ====
module dyn_phase_shift_fsm (
	input  logic                       CLK40,
	input  logic                       cmp_phs_rst_i,
	input  logic                       locked_i,
	input  logic                       phs_change_i,
	input  logic                       psdone_i,
	output logic                       psen_o,
	output logic                       busy_o,
	output clock_ctrl_pkg::phs_state_t state_o
);

	clock_ctrl_pkg::phs_state_t state;
	clock_ctrl_pkg::phs_state_t state_nxt;

	//------------------------------------------------------------------------
	// Next state
	//------------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			clock_ctrl_pkg::PS_IDLE: begin
				// Step only while the manager is locked
				if (locked_i && phs_change_i)
					state_nxt = clock_ctrl_pkg::PS_STEP;
			end
			clock_ctrl_pkg::PS_STEP: begin
				state_nxt = clock_ctrl_pkg::PS_WAIT;   // Single psen cycle
			end
			clock_ctrl_pkg::PS_WAIT: begin
				if (psdone_i)
					state_nxt = clock_ctrl_pkg::PS_SETTLE1;
			end
			clock_ctrl_pkg::PS_SETTLE1: begin
				state_nxt = clock_ctrl_pkg::PS_SETTLE2;
			end
			clock_ctrl_pkg::PS_SETTLE2: begin
				// Change flag is valid again from here
				state_nxt = clock_ctrl_pkg::PS_IDLE;
			end
			default: begin
				state_nxt = clock_ctrl_pkg::PS_IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK40 or posedge cmp_phs_rst_i) begin
		if (cmp_phs_rst_i)
			state <= clock_ctrl_pkg::PS_IDLE;
		else
			state <= state_nxt;
	end

	//------------------------------------------------------------------------
	// Outputs decoded from the state register
	//------------------------------------------------------------------------
	assign psen_o  = (state == clock_ctrl_pkg::PS_STEP);
	assign busy_o  = (state != clock_ctrl_pkg::PS_IDLE);
	assign state_o = state;

endmodule

// ==== clock_ctrl_top.sv ====
module clock_ctrl_top (
	input  logic                                 CLK40,
	input  logic                                 RST,
	input  logic                                 cmp_phs_jtag_rst_i,
	input  logic                                 resync_i,
	input  clock_ctrl_pkg::samp_phase_t          samp_clk_phase_i,
	input  logic                                 samp_clk_phs_chng_i,
	input  logic [clock_ctrl_pkg::CMP_SEL_W-1:0] cmp_clk_phase_i,
	input  logic                                 cmp_locked_i,
	input  logic                                 cmp_psdone_i,
	output clock_ctrl_pkg::samp_status_t         samp_status_o,
	output clock_ctrl_pkg::cmp_status_t          cmp_status_o,
	output logic                                 cmp_phs_rst_o
);

	logic                       lead_edg_resync;
	logic                       cap_phase;
	logic                       c20_phase_sel;
	logic                       samp_in_sel;
	logic                       rst_samp_mmcm;
	logic                       holdoff_req;
	logic                       dsr_resync;
	logic                       cmp_phs_rst;
	clock_ctrl_pkg::cmp_phase_t cmp_phase;
	logic                       phs_change;
	logic                       psen;
	logic                       psincdec;
	logic                       busy;
	clock_ctrl_pkg::phs_state_t phs_state;

	// Comparator side restarts with the board or from JTAG
	assign cmp_phs_rst = RST | cmp_phs_jtag_rst_i;

	//------------------------------------------------------------------------
	// Sampling clock side
	//------------------------------------------------------------------------
	resync_align resync_align_inst (
		.CLK40             (CLK40),
		.RST               (RST),
		.resync_i          (resync_i),
		.lead_edg_resync_o (lead_edg_resync),
		.cap_phase_o       (cap_phase),
		.c20_phase_sel_o   (c20_phase_sel)
	);

	samp_clk_ctrl samp_clk_ctrl_inst (
		.CLK40               (CLK40),
		.RST                 (RST),
		.half_sel_i          (samp_clk_phase_i.half_sel),
		.c20_phase_sel_i     (c20_phase_sel),
		.samp_clk_phs_chng_i (samp_clk_phs_chng_i),
		.samp_in_sel_o       (samp_in_sel),
		.rst_samp_mmcm_o     (rst_samp_mmcm),
		.holdoff_req_o       (holdoff_req)
	);

	dsr_holdoff dsr_holdoff_inst (
		.CLK40         (CLK40),
		.RST           (RST),
		.holdoff_req_i (holdoff_req),
		.dsr_resync_o  (dsr_resync)
	);

	//------------------------------------------------------------------------
	// Comparator clock side
	//------------------------------------------------------------------------
	cmp_phase_tracker cmp_phase_tracker_inst (
		.CLK40           (CLK40),
		.cmp_phs_rst_i   (cmp_phs_rst),
		.cmp_clk_phase_i (cmp_clk_phase_i),
		.psen_i          (psen),
		.cmp_phase_o     (cmp_phase),
		.psincdec_o      (psincdec),
		.phs_change_o    (phs_change)
	);

	dyn_phase_shift_fsm dyn_phase_shift_fsm_inst (
		.CLK40         (CLK40),
		.cmp_phs_rst_i (cmp_phs_rst),
		.locked_i      (cmp_locked_i),
		.phs_change_i  (phs_change),
		.psdone_i      (cmp_psdone_i),
		.psen_o        (psen),
		.busy_o        (busy),
		.state_o       (phs_state)
	);

	assign samp_status_o.lead_edg_resync = lead_edg_resync;
	assign samp_status_o.cap_phase       = cap_phase;
	assign samp_status_o.c20_phase_sel   = c20_phase_sel;
	assign samp_status_o.samp_in_sel     = samp_in_sel;
	assign samp_status_o.rst_samp_mmcm   = rst_samp_mmcm;
	assign samp_status_o.dsr_resync      = dsr_resync;

	// psen and psincdec also drive the external manager
	assign cmp_status_o.cmp_phase  = cmp_phase;
	assign cmp_status_o.phs_change = phs_change;
	assign cmp_status_o.psen       = psen;
	assign cmp_status_o.psincdec   = psincdec;
	assign cmp_status_o.busy       = busy;
	assign cmp_status_o.state      = phs_state;

	assign cmp_phs_rst_o = cmp_phs_rst;

endmodule

// ==== clock_ctrl_checker.sv ====
module clock_ctrl_checker (
	input  logic                                 CLK40,
	input  logic                                 RST,
	input  logic                                 cmp_phs_jtag_rst_i,
	input  logic                                 resync_i,
	input  clock_ctrl_pkg::samp_phase_t          samp_clk_phase_i,
	input  logic                                 samp_clk_phs_chng_i,
	input  logic [clock_ctrl_pkg::CMP_SEL_W-1:0] cmp_clk_phase_i,
	input  logic                                 cmp_locked_i,
	input  logic                                 cmp_psdone_i,
	input  clock_ctrl_pkg::samp_status_t         samp_status_i,
	input  clock_ctrl_pkg::cmp_status_t          cmp_status_i,
	input  logic                                 cmp_phs_rst_i,
	output int                                   err_cnt_o
);

	localparam int HOLDOFF_CYC = clock_ctrl_pkg::TICKS_PER_US * clock_ctrl_pkg::HOLDOFF_US;

	logic                       cphs_rst;
	logic                       m_resync_d1;
	logic                       m_edge_d1;
	logic                       m_cap;
	logic                       m_cap_d1;
	logic                       m_ena;
	logic                       m_div;
	logic                       m_c20;
	logic                       m_rst_d1;
	logic                       m_rst_d2;
	logic                       m_sel_d1;
	logic [clock_ctrl_pkg::RST_PIPE_LEN-1:0] m_pipe;
	int                         m_ho_left;   // Remaining holdoff cycles
	clock_ctrl_pkg::cmp_phase_t m_target;
	clock_ctrl_pkg::cmp_phase_t m_cur;
	logic                       m_inc;
	logic                       m_chg1;
	logic                       m_chg;
	clock_ctrl_pkg::phs_state_t m_st;
	logic                       m_edge;
	logic                       m_sel;
	logic                       m_pipe_in;
	logic                       m_req;
	logic                       prev_busy;
	int                         started;
	int                         cyc;
	int                         err_cnt;

	// Table entry i is i*1344/31, rounded to nearest
	function automatic clock_ctrl_pkg::cmp_phase_t phase_entry(input int i);
		return clock_ctrl_pkg::cmp_phase_t'((i * 2 * clock_ctrl_pkg::CMP_FULL_TURN + 31) / 62);
	endfunction

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("MISMATCH %s got 0x%0h exp 0x%0h at cycle %0d", name, got, exp, cyc);
		end
	endtask

	assign cphs_rst  = RST | cmp_phs_jtag_rst_i;
	assign m_edge    = resync_i & ~m_resync_d1;
	assign m_sel     = samp_clk_phase_i.half_sel ^ m_c20;
	assign m_pipe_in = (m_sel ^ m_sel_d1) | (~RST & m_rst_d2);
	assign m_req     = m_pipe_in | samp_clk_phs_chng_i;
	assign err_cnt_o = err_cnt;

	initial begin
		err_cnt   = 0;
		started   = 0;
		cyc       = 0;
		prev_busy = 1'b0;
	end

	//------------------------------------------------------------------------
	// Sampling side model
	//------------------------------------------------------------------------
	always @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			m_resync_d1 <= 1'b0;
			m_edge_d1   <= 1'b0;
			m_cap       <= 1'b0;
			m_cap_d1    <= 1'b0;
			m_ena       <= 1'b1;
			m_div       <= 1'b0;
			m_c20       <= 1'b0;
			m_pipe      <= '0;
			m_ho_left   <= 0;
		end else begin
			m_resync_d1 <= resync_i;
			m_edge_d1   <= m_edge;
			m_cap       <= (m_edge | m_edge_d1) & m_ena;
			m_cap_d1    <= m_cap;
			if (m_cap_d1)
				m_ena <= 1'b0;
			m_div <= m_edge ? 1'b0 : ~m_div;
			if (m_cap)
				m_c20 <= m_div;
			m_pipe <= {m_pipe[clock_ctrl_pkg::RST_PIPE_LEN-2:0], m_pipe_in};
			// New request only counts when idle or on the last cycle
			if (m_req && m_ho_left <= 1)
				m_ho_left <= HOLDOFF_CYC;
			else if (m_ho_left > 0)
				m_ho_left <= m_ho_left - 1;
		end
	end

	always @(posedge CLK40) begin
		m_rst_d1 <= RST;
		m_rst_d2 <= m_rst_d1;
		m_sel_d1 <= m_sel;
		started  <= started + 1;
		cyc      <= cyc + 1;
	end

	//------------------------------------------------------------------------
	// Comparator side model
	//------------------------------------------------------------------------
	always @(posedge CLK40) begin
		m_target <= phase_entry(cmp_clk_phase_i);
	end

	always @(posedge CLK40 or posedge cphs_rst) begin
		if (cphs_rst) begin
			m_inc  <= 1'b0;
			m_chg1 <= 1'b0;
			m_chg  <= 1'b0;
			m_cur  <= '0;
			m_st   <= clock_ctrl_pkg::PS_IDLE;
		end else begin
			m_inc  <= (m_target > m_cur);
			m_chg1 <= (m_target != m_cur);
			m_chg  <= m_chg1;
			if (m_st == clock_ctrl_pkg::PS_STEP)
				m_cur <= m_inc ? m_cur + 1'b1 : m_cur - 1'b1;
			case (m_st)
				clock_ctrl_pkg::PS_IDLE:
					if (cmp_locked_i && m_chg)
						m_st <= clock_ctrl_pkg::PS_STEP;
				clock_ctrl_pkg::PS_STEP:    m_st <= clock_ctrl_pkg::PS_WAIT;
				clock_ctrl_pkg::PS_WAIT:
					if (cmp_psdone_i)
						m_st <= clock_ctrl_pkg::PS_SETTLE1;
				clock_ctrl_pkg::PS_SETTLE1: m_st <= clock_ctrl_pkg::PS_SETTLE2;
				default:                    m_st <= clock_ctrl_pkg::PS_IDLE;
			endcase
		end
	end

	// Compare away from the rising edge
	always @(negedge CLK40) begin
		if (started >= 2) begin
			check_field("lead_edg_resync", samp_status_i.lead_edg_resync, m_edge);
			check_field("cap_phase", samp_status_i.cap_phase, m_cap);
			check_field("c20_phase_sel", samp_status_i.c20_phase_sel, m_c20);
			check_field("samp_in_sel", samp_status_i.samp_in_sel, m_sel);
			check_field("rst_samp_mmcm", samp_status_i.rst_samp_mmcm, |m_pipe);
			check_field("dsr_resync", samp_status_i.dsr_resync, m_ho_left > 0);
			check_field("cmp_phs_rst", cmp_phs_rst_i, cphs_rst);
			check_field("cmp_phase", cmp_status_i.cmp_phase, m_target);
			check_field("phs_change", cmp_status_i.phs_change, m_chg);
			check_field("psen", cmp_status_i.psen, m_st == clock_ctrl_pkg::PS_STEP);
			check_field("psincdec", cmp_status_i.psincdec, m_inc);
			check_field("busy", cmp_status_i.busy, m_st != clock_ctrl_pkg::PS_IDLE);
			check_field("state", cmp_status_i.state, m_st);
			if (cmp_status_i.psen && prev_busy) begin
				err_cnt++;
				$display("psen rose while an earlier step was still busy at cycle %0d", cyc);
			end
		end
		prev_busy = cmp_status_i.busy;
	end

endmodule

// ==== tb_clock_ctrl.sv ====
module tb_clock_ctrl;

	localparam int MOVE_LIMIT = clock_ctrl_pkg::CMP_FULL_TURN * 14 + 50;
	// Three holdoffs, six phase moves of up to a full turn, some slack
	localparam int RUN_LIMIT  = 2 * (3 * 4100 + 6 * clock_ctrl_pkg::CMP_FULL_TURN * 12 + 3000);

	logic                                 CLK40;
	logic                                 RST;
	logic                                 jtag_rst;
	logic                                 resync;
	clock_ctrl_pkg::samp_phase_t          samp_phase;
	logic                                 phs_chng;
	logic [clock_ctrl_pkg::CMP_SEL_W-1:0] cmp_code;
	logic                                 locked;
	logic                                 psdone;
	clock_ctrl_pkg::samp_status_t         samp_status;
	clock_ctrl_pkg::cmp_status_t          cmp_status;
	logic                                 cmp_phs_rst;

	int chk_errs;
	int tb_errs;
	int last_errs;
	int n_tests;
	int cyc;
	int done_dly;
	int n_a;
	int n_b;
	int k;
	int hold;
	int second;
	logic saw_dsr;
	logic [clock_ctrl_pkg::CMP_SEL_W-1:0] new_code;

	clock_ctrl_top clock_ctrl_top_inst (
		.CLK40               (CLK40),
		.RST                 (RST),
		.cmp_phs_jtag_rst_i  (jtag_rst),
		.resync_i            (resync),
		.samp_clk_phase_i    (samp_phase),
		.samp_clk_phs_chng_i (phs_chng),
		.cmp_clk_phase_i     (cmp_code),
		.cmp_locked_i        (locked),
		.cmp_psdone_i        (psdone),
		.samp_status_o       (samp_status),
		.cmp_status_o        (cmp_status),
		.cmp_phs_rst_o       (cmp_phs_rst)
	);

	clock_ctrl_checker clock_ctrl_checker_inst (
		.CLK40               (CLK40),
		.RST                 (RST),
		.cmp_phs_jtag_rst_i  (jtag_rst),
		.resync_i            (resync),
		.samp_clk_phase_i    (samp_phase),
		.samp_clk_phs_chng_i (phs_chng),
		.cmp_clk_phase_i     (cmp_code),
		.cmp_locked_i        (locked),
		.cmp_psdone_i        (psdone),
		.samp_status_i       (samp_status),
		.cmp_status_i        (cmp_status),
		.cmp_phs_rst_i       (cmp_phs_rst),
		.err_cnt_o           (chk_errs)
	);

	always #5 CLK40 = ~CLK40;

	function automatic int phase_entry(input int i);
		return (i * 2 * clock_ctrl_pkg::CMP_FULL_TURN + 31) / 62;
	endfunction

	task automatic expect_count(input string name, input int got, input int exp);
		if (got != exp) begin
			tb_errs++;
			$display("MISMATCH %s got 0x%0h exp 0x%0h", name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = chk_errs + tb_errs;
		n_tests++;
		$display("test %0d %s: %0d errors", n_tests, name, errs - last_errs);
		last_errs = errs;
	endtask

	// Wait until neither the pipe nor the holdoff is active
	task automatic wait_samp_idle();
		int n;
		n = 0;
		@(negedge CLK40);
		while ((samp_status.dsr_resync || samp_status.rst_samp_mmcm) && n < 5000) begin
			@(negedge CLK40);
			n++;
		end
		if (n >= 5000) begin
			tb_errs++;
			$display("sampling side did not go idle within 5000 cycles");
		end
	endtask

	// Count steps until busy and phs_change are both low
	task automatic count_steps(input logic up, output int pulses);
		int n;
		pulses = 0;
		n = 0;
		do begin
			@(negedge CLK40);
			n++;
			if (cmp_status.psen) begin
				pulses++;
				if (cmp_status.psincdec !== up) begin
					tb_errs++;
					$display("MISMATCH psincdec got 0x%0h exp 0x%0h", cmp_status.psincdec, up);
				end
			end
		end while ((n < 4 || cmp_status.busy || cmp_status.phs_change) && n < MOVE_LIMIT);
		if (n >= MOVE_LIMIT) begin
			tb_errs++;
			$display("phase move did not complete within %0d cycles", MOVE_LIMIT);
		end
	endtask

	task automatic run_move(input logic [clock_ctrl_pkg::CMP_SEL_W-1:0] code);
		int old_val;
		int new_val;
		int pulses;
		old_val = phase_entry(cmp_code);
		new_val = phase_entry(code);
		@(posedge CLK40);
		cmp_code <= code;
		@(posedge CLK40);
		@(negedge CLK40);
		expect_count("cmp_phase", cmp_status.cmp_phase, new_val);
		count_steps(new_val > old_val, pulses);
		expect_count("psen_count", pulses, (new_val > old_val) ? new_val - old_val
			: old_val - new_val);
	endtask

	// Clock manager answers each psen after 1 to 8 cycles
	always @(posedge CLK40) begin
		psdone <= 1'b0;
		if (cmp_phs_rst)
			done_dly <= 0;
		else if (cmp_status.psen)
			done_dly <= $urandom_range(8, 1);
		else if (done_dly == 1) begin
			psdone   <= 1'b1;
			done_dly <= 0;
		end else if (done_dly > 1)
			done_dly <= done_dly - 1;
	end

	always @(posedge CLK40) begin
		cyc <= cyc + 1;
		if (cyc >= RUN_LIMIT) begin
			$display("timeout after %0d cycles", cyc);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'he9e4_86ea));
		CLK40      = 1'b0;
		RST        = 1'b1;
		jtag_rst   = 1'b0;
		resync     = 1'b0;
		samp_phase = '0;
		phs_chng   = 1'b0;
		cmp_code   = '0;
		locked     = 1'b1;
		psdone     = 1'b0;
		done_dly   = 0;
		cyc        = 0;
		tb_errs    = 0;
		last_errs  = 0;
		n_tests    = 0;

		//--------------------------------------------------------------------
		// Reset values then manager reset and holdoff after release
		//--------------------------------------------------------------------
		repeat (4) @(posedge CLK40);
		RST <= 1'b0;
		@(negedge CLK40);
		expect_count("psen", cmp_status.psen, 0);
		expect_count("busy", cmp_status.busy, 0);
		expect_count("phs_change", cmp_status.phs_change, 0);
		expect_count("cap_phase", samp_status.cap_phase, 0);
		expect_count("c20_phase_sel", samp_status.c20_phase_sel, 0);
		expect_count("state", cmp_status.state, clock_ctrl_pkg::PS_IDLE);
		n_a = 0;
		saw_dsr = 1'b0;
		repeat (20) begin
			@(negedge CLK40);
			n_a += samp_status.rst_samp_mmcm;
			saw_dsr |= samp_status.dsr_resync;
		end
		expect_count("rst_samp_mmcm_len", n_a, 9);
		expect_count("dsr_resync", saw_dsr, 1);
		wait_samp_idle();
		end_test("reset");

		// Only the first resync captures the divider phase
		repeat ($urandom_range(40, 5)) @(posedge CLK40);
		hold = $urandom_range(4, 1);
		n_a = 0;
		n_b = 0;
		for (k = 0; k < 12; k++) begin
			@(posedge CLK40);
			resync <= (k < hold);
			@(negedge CLK40);
			n_a += samp_status.lead_edg_resync;
			n_b += samp_status.cap_phase;
		end
		expect_count("lead_edg_resync_len", n_a, 1);
		expect_count("cap_phase_len", n_b, 2);
		// Divider reads 0 then 1 in the window and the later load wins
		expect_count("c20_phase_sel", samp_status.c20_phase_sel, 1);
		expect_count("samp_in_sel", samp_status.samp_in_sel, samp_phase.half_sel ^ 1'b1);
		wait_samp_idle();
		repeat ($urandom_range(9, 1)) @(posedge CLK40);
		resync <= 1'b1;
		@(posedge CLK40);
		resync <= 1'b0;
		repeat (12) @(negedge CLK40);
		expect_count("c20_phase_sel", samp_status.c20_phase_sel, 1);
		wait_samp_idle();
		end_test("resync");

		// Half select toggle resets the sampling manager
		@(posedge CLK40);
		samp_phase.half_sel <= ~samp_phase.half_sel;
		n_a = 0;
		saw_dsr = 1'b0;
		repeat (20) begin
			@(negedge CLK40);
			n_a += samp_status.rst_samp_mmcm;
			saw_dsr |= samp_status.dsr_resync;
		end
		expect_count("rst_samp_mmcm_len", n_a, 8);
		expect_count("dsr_resync", saw_dsr, 1);
		wait_samp_idle();
		end_test("half_sel");

		// Holdoff length with a second request inside the window
		second = $urandom_range(3000, 100);
		n_a = 0;
		k = 0;
		do begin
			@(posedge CLK40);
			phs_chng <= (k == 0 || k == second);
			@(negedge CLK40);
			n_a += samp_status.dsr_resync;
			k++;
		end while ((k < 4 || samp_status.dsr_resync) && k < 5000);
		expect_count("dsr_resync_len", n_a, 4000);
		end_test("holdoff");

		// Random comparator phase moves
		repeat (4) begin
			new_code = $urandom_range(31, 0);
			if (new_code == cmp_code)
				new_code = new_code + 1'b1;
			run_move(new_code);
		end
		end_test("phase_moves");

		// JTAG reset in mid move restarts from phase 0
		new_code = $urandom_range(31, 16);
		if (new_code == cmp_code)
			new_code = new_code - 5'd8;
		@(posedge CLK40);
		cmp_code <= new_code;
		repeat ($urandom_range(200, 20)) @(posedge CLK40);
		jtag_rst <= 1'b1;
		@(negedge CLK40);
		expect_count("state", cmp_status.state, clock_ctrl_pkg::PS_IDLE);
		@(posedge CLK40);
		jtag_rst <= 1'b0;
		count_steps(1'b1, n_a);
		expect_count("psen_count", n_a, phase_entry(new_code));
		end_test("jtag_reset");

		repeat (4) @(posedge CLK40);
		$display("tests %0d, checker errors %0d, test errors %0d", n_tests, chk_errs, tb_errs);
		if (chk_errs + tb_errs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== cmp_phase.mem ====
// Comparator phase table, one 11-bit fine phase per line, entry i = round(i*1344/31)
000
02B
057
082
0AD
0D9
104
12F
15B
186
1B2
1DD
208
234
25F
28A
2B6
2E1
30C
338
363
38E
3BA
3E5
411
43C
467
493
4BE
4E9
515
540

// ==== clock_ctrl.f ====
clock_ctrl_pkg.sv
resync_align.sv
samp_clk_ctrl.sv
dsr_holdoff.sv
cmp_phase_tracker.sv
dyn_phase_shift_fsm.sv
clock_ctrl_top.sv
clock_ctrl_checker.sv
tb_clock_ctrl.sv

// ==== Bender.yml ====
package:
  name: clock_ctrl

sources:
  - clock_ctrl_pkg.sv
  - resync_align.sv
  - samp_clk_ctrl.sv
  - dsr_holdoff.sv
  - cmp_phase_tracker.sv
  - dyn_phase_shift_fsm.sv
  - clock_ctrl_top.sv
  - target: simulation
    files:
      - clock_ctrl_checker.sv
      - tb_clock_ctrl.sv
